// ==== build.f ====
hw/mem_pkg.sv
hw/sync_fifo.sv
hw/byte_lane_map.sv
hw/load_extract.sv
hw/mem_sequencer.sv
hw/mem_ctrl_top.sv
test/wb_mem_model.sv
test/tb_mem_ctrl.sv

// ==== hw/byte_lane_map.sv ====
// ======================================
// byte_lane_map: lane select, store data
// positioning and alignment check
// ======================================

`timescale 1ns/1ps

module byte_lane_map import mem_pkg::*; (
	input  logic [SIZEW-1:0]   size_i,
	input  logic [LANE_AW-1:0] adr_lo_i,
	input  logic [DWID-1:0]    dat_i,
	output logic [SELW-1:0]    sel_o,
	output logic [DWID-1:0]    wdat_o,
	output logic               misaligned_o
);

	logic [SELW-1:0] sel_base;	// select for lane 0

	// an access must start on a multiple of its own size
	always_comb begin
		sel_base = '0;
		misaligned_o = 1'b0;
		case (size_i)
		SZ_BYTE: begin
			sel_base = SELW'(8'h01);
		end
		SZ_WYDE: begin
			sel_base = SELW'(8'h03);
			misaligned_o = adr_lo_i[0];
		end
		SZ_TETRA: begin
			sel_base = SELW'(8'h0f);
			misaligned_o = |adr_lo_i[1:0];
		end
		default: begin	// octa, whole word only
			sel_base = SELW'(8'hff);
			misaligned_o = |adr_lo_i;
		end
		endcase
	end

	assign sel_o  = sel_base << adr_lo_i;
	assign wdat_o = dat_i << {adr_lo_i, 3'b000};	// eight bits per lane

endmodule

// ==== hw/load_extract.sv ====
// ======================================
// load_extract: read word alignment and
// sign or zero extension
// ======================================

`timescale 1ns/1ps

module load_extract import mem_pkg::*; (
	input  logic [DWID-1:0]    rdat_i,
	input  logic [LANE_AW-1:0] adr_lo_i,
	input  logic [SIZEW-1:0]   size_i,
	input  logic               unsigned_i,
	output logic [DWID-1:0]    res_o
);

	logic [DWID-1:0] shifted;
	logic fill;	// top bit of kept field, or zero

	always_comb begin
		shifted = rdat_i >> {adr_lo_i, 3'b000};
		fill = 1'b0;
		case (size_i)
		SZ_BYTE: begin
			fill = ~unsigned_i & shifted[7];
			res_o = {{(DWID-8){fill}}, shifted[7:0]};
		end
		SZ_WYDE: begin
			fill = ~unsigned_i & shifted[15];
			res_o = {{(DWID-16){fill}}, shifted[15:0]};
		end
		SZ_TETRA: begin
			fill = ~unsigned_i & shifted[31];
			res_o = {{(DWID-32){fill}}, shifted[31:0]};
		end
		default: res_o = shifted;	// octa needs no extension
		endcase
	end

endmodule

// ==== hw/mem_ctrl_top.sv ====
// ======================================
// mem_ctrl_top: request FIFO, sequencer
// and response FIFO
// ======================================

`timescale 1ns/1ps

module mem_ctrl_top import mem_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	// request side
	input  logic              req_wr_i,
	input  logic [FUNCW-1:0]  req_func_i,
	input  logic [SIZEW-1:0]  req_size_i,
	input  logic              req_unsigned_i,
	input  logic [TIDW-1:0]   req_tid_i,
	input  logic [AWID-1:0]   req_adr_i,
	input  logic [DWID-1:0]   req_dat_i,
	output logic              req_full_o,
	// response side
	output logic              resp_empty_o,
	output logic [TIDW-1:0]   resp_tid_o,
	output logic [DWID-1:0]   resp_res_o,
	output logic [CAUSEW-1:0] resp_cause_o,
	input  logic              resp_rd_i,
	// Wishbone master
	output logic              wb_cyc_o,
	output logic              wb_stb_o,
	output logic              wb_we_o,
	output logic [SELW-1:0]   wb_sel_o,
	output logic [AWID-1:0]   wb_adr_o,
	output logic [DWID-1:0]   wb_dat_o,
	input  logic              wb_ack_i,
	input  logic [DWID-1:0]   wb_dat_i
);

	logic [REQ_W-1:0] req_word, req_head;
	logic [RESP_W-1:0] resp_word, resp_head;
	logic req_empty, req_rd, resp_full, resp_wr;
	logic [FUNCW-1:0] hd_func;
	logic [SIZEW-1:0] hd_size;
	logic hd_unsigned;
	logic [TIDW-1:0] hd_tid, sq_tid;
	logic [AWID-1:0] hd_adr;
	logic [DWID-1:0] hd_dat, sq_res;
	logic [CAUSEW-1:0] sq_cause;

	// field order is func, size, unsigned, tid, address, data
	assign req_word = {req_func_i, req_size_i, req_unsigned_i, req_tid_i, req_adr_i, req_dat_i};
	assign {hd_func, hd_size, hd_unsigned, hd_tid, hd_adr, hd_dat} = req_head;
	assign resp_word = {sq_tid, sq_res, sq_cause};
	assign {resp_tid_o, resp_res_o, resp_cause_o} = resp_head;

	sync_fifo #(.WIDTH(REQ_W)) u_req_fifo (
		.clk(clk), .rst(rst),
		.wr_i(req_wr_i), .din_i(req_word),
		.rd_i(req_rd), .dout_o(req_head),
		.full_o(req_full_o), .empty_o(req_empty)
	);

	mem_sequencer u_seq (
		.clk(clk), .rst(rst),
		.req_empty_i(req_empty), .req_rd_o(req_rd),
		.req_func_i(hd_func), .req_size_i(hd_size), .req_unsigned_i(hd_unsigned),
		.req_tid_i(hd_tid), .req_adr_i(hd_adr), .req_dat_i(hd_dat),
		.resp_full_i(resp_full), .resp_wr_o(resp_wr),
		.resp_tid_o(sq_tid), .resp_res_o(sq_res), .resp_cause_o(sq_cause),
		.wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o),
		.wb_sel_o(wb_sel_o), .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o),
		.wb_ack_i(wb_ack_i), .wb_dat_i(wb_dat_i)
	);

	sync_fifo #(.WIDTH(RESP_W)) u_resp_fifo (
		.clk(clk), .rst(rst),
		.wr_i(resp_wr), .din_i(resp_word),
		.rd_i(resp_rd_i), .dout_o(resp_head),
		.full_o(resp_full), .empty_o(resp_empty_o)
	);

endmodule

// ==== hw/mem_pkg.sv ====
// ======================================
// shared widths and codes of the memory
// request controller: bus, request and
// response fields, causes, FIFO sizing
// ======================================

package mem_pkg;

	// ======================================
	// bus and field widths
	// ======================================
	localparam int AWID    = 32;	// byte address
	localparam int DWID    = 64;	// bus word and result
	localparam int SELW    = 8;	// byte lanes
	localparam int LANE_AW = 3;	// low address bits picking a lane
	localparam int TIDW    = 4;
	localparam int FUNCW   = 2;
	localparam int SIZEW   = 2;
	localparam int CAUSEW  = 16;

	// function codes, 3 is unknown
	localparam logic [FUNCW-1:0] FN_LOAD  = 2'd0;
	localparam logic [FUNCW-1:0] FN_STORE = 2'd1;
	localparam logic [FUNCW-1:0] FN_LEA   = 2'd2;

	// access sizes, 1 2 4 8 bytes
	localparam logic [SIZEW-1:0] SZ_BYTE  = 2'd0;
	localparam logic [SIZEW-1:0] SZ_WYDE  = 2'd1;
	localparam logic [SIZEW-1:0] SZ_TETRA = 2'd2;
	localparam logic [SIZEW-1:0] SZ_OCTA  = 2'd3;

	// fault causes
	localparam logic [CAUSEW-1:0] CAUSE_NONE  = 16'h0000;
	localparam logic [CAUSEW-1:0] CAUSE_ALIGN = 16'h8030;	// crosses lane alignment
	localparam logic [CAUSEW-1:0] CAUSE_FUNC  = 16'h8031;	// bad function code

	// ======================================
	// queues and sequencer
	// ======================================
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW    = 4;
	localparam int REQ_W  = FUNCW + SIZEW + 1 + TIDW + AWID + DWID;
	localparam int RESP_W = TIDW + DWID + CAUSEW;

	localparam int STW = 2;
	localparam logic [STW-1:0] ST_IDLE   = 2'd0;
	localparam logic [STW-1:0] ST_DECODE = 2'd1;
	localparam logic [STW-1:0] ST_BUS    = 2'd2;
	localparam logic [STW-1:0] ST_RESP   = 2'd3;

endpackage

// ==== hw/mem_sequencer.sv ====
// ======================================
// mem_sequencer: pops requests, runs one
// Wishbone classic cycle per load/store,
// pushes tagged responses
// ======================================

`timescale 1ns/1ps

module mem_sequencer import mem_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	// request FIFO head
	input  logic              req_empty_i,
	output logic              req_rd_o,
	input  logic [FUNCW-1:0]  req_func_i,
	input  logic [SIZEW-1:0]  req_size_i,
	input  logic              req_unsigned_i,
	input  logic [TIDW-1:0]   req_tid_i,
	input  logic [AWID-1:0]   req_adr_i,
	input  logic [DWID-1:0]   req_dat_i,
	// response FIFO tail
	input  logic              resp_full_i,
	output logic              resp_wr_o,
	output logic [TIDW-1:0]   resp_tid_o,
	output logic [DWID-1:0]   resp_res_o,
	output logic [CAUSEW-1:0] resp_cause_o,
	// Wishbone master
	output logic              wb_cyc_o,
	output logic              wb_stb_o,
	output logic              wb_we_o,
	output logic [SELW-1:0]   wb_sel_o,
	output logic [AWID-1:0]   wb_adr_o,
	output logic [DWID-1:0]   wb_dat_o,
	input  logic              wb_ack_i,
	input  logic [DWID-1:0]   wb_dat_i
);

	logic [STW-1:0] state;
	logic [FUNCW-1:0] func_q;
	logic [SIZEW-1:0] size_q;
	logic uns_q;
	logic [TIDW-1:0] tid_q;
	logic [AWID-1:0] adr_q;
	logic [DWID-1:0] dat_q;
	logic [DWID-1:0] res_q;
	logic [CAUSEW-1:0] cause_q;
	logic [SELW-1:0] lane_sel;
	logic [DWID-1:0] lane_wdat, ext_res;
	logic misaligned, is_mem;

	byte_lane_map u_lane (
		.size_i       (size_q),
		.adr_lo_i     (adr_q[LANE_AW-1:0]),
		.dat_i        (dat_q),
		.sel_o        (lane_sel),
		.wdat_o       (lane_wdat),
		.misaligned_o (misaligned)
	);

	// works on the live bus word, sampled at ack
	load_extract u_extract (
		.rdat_i     (wb_dat_i),
		.adr_lo_i   (adr_q[LANE_AW-1:0]),
		.size_i     (size_q),
		.unsigned_i (uns_q),
		.res_o      (ext_res)
	);

	assign is_mem = (func_q == FN_LOAD) || (func_q == FN_STORE);
	assign req_rd_o = (state == ST_IDLE) && !req_empty_i && !resp_full_i;
	assign resp_wr_o = (state == ST_RESP);	// one push per request
	assign resp_tid_o = tid_q;
	assign resp_res_o = res_q;
	assign resp_cause_o = cause_q;

	// ======================================
	// control
	// ======================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			wb_cyc_o <= 1'b0;
			wb_stb_o <= 1'b0;
			wb_we_o <= 1'b0;
		end else begin
			case (state)
			ST_IDLE: if (req_rd_o) state <= ST_DECODE;
			ST_DECODE: begin
				if (is_mem && !misaligned) begin
					wb_cyc_o <= 1'b1;
					wb_stb_o <= 1'b1;
					wb_we_o <= (func_q == FN_STORE);
					state <= ST_BUS;
				end else
					state <= ST_RESP;	// lea or fault, no bus cycle
			end
			ST_BUS: if (wb_ack_i) begin
				wb_cyc_o <= 1'b0;
				wb_stb_o <= 1'b0;
				wb_we_o <= 1'b0;
				state <= ST_RESP;
			end
			default: state <= ST_IDLE;
			endcase
		end
	end

	// ======================================
	// datapath
	// ======================================
	always_ff @(posedge clk) begin
		if (req_rd_o) begin
			func_q <= req_func_i;
			size_q <= req_size_i;
			uns_q <= req_unsigned_i;
			tid_q <= req_tid_i;
			adr_q <= req_adr_i;
			dat_q <= req_dat_i;
		end
		case (state)
		ST_DECODE: begin
			res_q <= '0;
			cause_q <= CAUSE_NONE;
			wb_sel_o <= lane_sel;
			wb_adr_o <= {adr_q[AWID-1:LANE_AW], {LANE_AW{1'b0}}};
			wb_dat_o <= lane_wdat;
			if (func_q == FN_LEA)
				res_q <= {{(DWID-AWID){1'b0}}, adr_q};
			else if (!is_mem)
				cause_q <= CAUSE_FUNC;
			else if (misaligned)
				cause_q <= CAUSE_ALIGN;
		end
		ST_BUS: if (wb_ack_i && !wb_we_o) res_q <= ext_res;	// stores answer zero
		default: ;
		endcase
	end

	a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb_o |-> wb_cyc_o);
	a_hold_until_ack: assert property (@(posedge clk) disable iff (rst)
		(wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o) && $stable(wb_sel_o)
		&& $stable(wb_we_o) && $stable(wb_dat_o)));

endmodule

// ==== hw/sync_fifo.sv ====
// ======================================
// sync_fifo: first-word-fall-through
// synchronous FIFO of FIFO_DEPTH words
// ======================================

`timescale 1ns/1ps

module sync_fifo import mem_pkg::*; #(
	parameter int WIDTH = 8
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             wr_i,
	input  logic [WIDTH-1:0] din_i,
	input  logic             rd_i,
	output logic [WIDTH-1:0] dout_o,
	output logic             full_o,
	output logic             empty_o
);

	logic [WIDTH-1:0] mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr, rd_ptr;	// wrap at depth
	logic [FIFO_AW:0] count;
	logic do_wr, do_rd;

	assign full_o  = (count == (FIFO_AW+1)'(FIFO_DEPTH));
	assign empty_o = (count == '0);
	assign do_wr   = wr_i && !full_o;
	assign do_rd   = rd_i && !empty_o;
	assign dout_o  = mem[rd_ptr];	// head shows with no read delay

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(wr_i && full_o));
	a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(rd_i && empty_o));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# builds the memory controller testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f build.f \
	--top-module tb_mem_ctrl \
	-o tb_mem_ctrl

./obj_dir/tb_mem_ctrl

// ==== test/tb_mem_ctrl.sv ====
// ======================================
// testbench for the memory request
// controller with stimulus, a reference
// model, response and bus address
// compare, and timeouts
// ======================================

`timescale 1ns/1ps

module tb_mem_ctrl import mem_pkg::*; ();

	localparam int TMO = 1000;	// cycles allowed per wait

	logic clk;
	logic rst;
	logic req_wr, req_uns, req_full;
	logic [FUNCW-1:0] req_func;
	logic [SIZEW-1:0] req_size;
	logic [TIDW-1:0] req_tid, resp_tid, tid_next;
	logic [AWID-1:0] req_adr, wb_adr;
	logic [DWID-1:0] req_dat, resp_res, wb_dat_m, wb_dat_s;
	logic [CAUSEW-1:0] resp_cause;
	logic resp_empty, resp_rd;
	logic wb_cyc, wb_stb, wb_we, wb_ack;
	logic [SELW-1:0] wb_sel;
	logic [31:0] bus_count;

	logic [DWID-1:0] shadow [256];
	logic [RESP_W-1:0] exp_q [$];	// tid, result, cause
	logic [AWID-1:0] bus_adr_q [$];	// word address of each expected bus cycle
	integer seed;
	string test_name;
	logic drain_en;

	initial clk = 1'b0;
	always #10 clk = ~clk;

	mem_ctrl_top u_mem_ctrl_top (
		.clk(clk), .rst(rst),
		.req_wr_i(req_wr), .req_func_i(req_func), .req_size_i(req_size),
		.req_unsigned_i(req_uns), .req_tid_i(req_tid), .req_adr_i(req_adr),
		.req_dat_i(req_dat), .req_full_o(req_full),
		.resp_empty_o(resp_empty), .resp_tid_o(resp_tid), .resp_res_o(resp_res),
		.resp_cause_o(resp_cause), .resp_rd_i(resp_rd),
		.wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_sel_o(wb_sel),
		.wb_adr_o(wb_adr), .wb_dat_o(wb_dat_m), .wb_ack_i(wb_ack), .wb_dat_i(wb_dat_s)
	);

	wb_mem_model u_mem (
		.clk(clk), .rst(rst),
		.wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_sel_i(wb_sel),
		.wb_adr_i(wb_adr), .wb_dat_i(wb_dat_m), .wb_ack_o(wb_ack), .wb_dat_o(wb_dat_s),
		.cyc_count_o(bus_count)
	);

	// ========================================
	// reference model
	// ========================================
	function automatic logic [RESP_W-1:0] predict(input logic [FUNCW-1:0] func,
		input logic [SIZEW-1:0] size, input logic uns, input logic [TIDW-1:0] tid,
		input logic [AWID-1:0] adr, input logic [DWID-1:0] dat);
		logic [DWID-1:0] res, word;
		logic [CAUSEW-1:0] cause;
		logic [7:0] idx;
		logic top;
		int nbytes, lane_i;
		nbytes = 1 << size;
		lane_i = int'(adr[2:0]);
		idx = adr[10:3];
		res = '0;
		cause = CAUSE_NONE;
		if (func == FN_LEA) begin
			res = {32'h0, adr};
		end else if (func != FN_LOAD && func != FN_STORE) begin
			cause = CAUSE_FUNC;
		end else if (lane_i % nbytes != 0) begin
			cause = CAUSE_ALIGN;	// memory left alone
		end else if (func == FN_STORE) begin
			for (int b = 0; b < nbytes; b++)
				shadow[idx][8*(lane_i+b) +: 8] = dat[8*b +: 8];
		end else begin
			word = shadow[idx];
			top = word[8*(lane_i+nbytes)-1];	// sign of the field
			for (int b = 0; b < 8; b++)
				if (b < nbytes)
					res[8*b +: 8] = word[8*(lane_i+b) +: 8];
				else
					res[8*b +: 8] = (uns || !top) ? 8'h00 : 8'hff;
		end
		return {tid, res, cause};
	endfunction

	task automatic abort_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_res(input logic [DWID-1:0] want, input logic [DWID-1:0] got);
		if (got !== want) begin
			$display("FAILED %s result: expected %h actual %h", test_name, want, got);
			abort_run();
		end
	endtask

	task automatic check_cause(input logic [CAUSEW-1:0] want, input logic [CAUSEW-1:0] got);
		if (got !== want) begin
			$display("FAILED %s cause: expected %h actual %h", test_name, want, got);
			abort_run();
		end
	endtask

	task automatic check_tid(input logic [TIDW-1:0] want, input logic [TIDW-1:0] got);
		if (got !== want) begin
			$display("FAILED %s tid: expected %h actual %h", test_name, want, got);
			abort_run();
		end
	endtask

	task automatic check_adr(input logic [AWID-1:0] want, input logic [AWID-1:0] got);
		if (got !== want) begin
			$display("FAILED %s bus address: expected %h actual %h", test_name, want, got);
			abort_run();
		end
	endtask

	// one request write after waiting for room
	task automatic issue(input logic [FUNCW-1:0] func, input logic [SIZEW-1:0] size,
		input logic uns, input logic [AWID-1:0] adr, input logic [DWID-1:0] dat);
		int t;
		logic [RESP_W-1:0] want;
		t = 0;
		@(negedge clk);
		while (req_full) begin
			if (t == TMO) begin
				$display("timeout: request FIFO stayed full for %0d cycles", TMO);
				abort_run();
			end else begin
				t++;
				@(negedge clk);
			end
		end
		@(posedge clk);
		req_wr <= 1'b1;
		req_func <= func;
		req_size <= size;
		req_uns <= uns;
		req_tid <= tid_next;
		req_adr <= adr;
		req_dat <= dat;
		want = predict(func, size, uns, tid_next, adr, dat);
		exp_q.push_back(want);
		if ((func == FN_LOAD || func == FN_STORE) && want[CAUSEW-1:0] == CAUSE_NONE)
			bus_adr_q.push_back({adr[AWID-1:3], 3'b000});	// whole bus word
		tid_next = tid_next + 1'b1;
		@(posedge clk);
		req_wr <= 1'b0;
	endtask

	task automatic wait_drained();
		int t;
		t = 0;
		while (exp_q.size() != 0) begin
			if (t == TMO) begin
				$display("timeout: %0d responses still missing", exp_q.size());
				abort_run();
			end else begin
				t++;
				@(negedge clk);
			end
		end
	endtask

	// ========================================
	// response compare
	// ========================================
	initial begin : compare_responses
		logic [RESP_W-1:0] want;
		resp_rd = 1'b0;
		forever begin
			@(negedge clk);
			if (drain_en && !resp_empty) begin
				if (exp_q.size() == 0) begin
					$display("a response arrived that no request expects");
					abort_run();
				end else begin
					want = exp_q.pop_front();
					check_tid(want[RESP_W-1 -: TIDW], resp_tid);
					check_res(want[CAUSEW +: DWID], resp_res);
					check_cause(want[CAUSEW-1:0], resp_cause);
					@(posedge clk);
					resp_rd <= 1'b1;	// pop the head just checked
					@(posedge clk);
					resp_rd <= 1'b0;
				end
			end
		end
	end

	// address of each bus cycle, taken as stb rises
	initial begin : compare_bus_address
		logic stb_prev;
		stb_prev = 1'b0;
		forever begin
			@(negedge clk);
			if (wb_stb === 1'b1 && !stb_prev) begin
				if (bus_adr_q.size() == 0) begin
					$display("a bus cycle started that no request expects");
					abort_run();
				end else begin
					check_adr(bus_adr_q.pop_front(), wb_adr);
				end
			end
			stb_prev = (wb_stb === 1'b1);
		end
	end

	// ========================================
	// stimulus
	// ========================================
	initial begin : stimulus
		logic [AWID-1:0] adr;
		logic [SIZEW-1:0] sz;
		logic [FUNCW-1:0] fn;
		logic [31:0] bus_before;
		logic full_seen;
		int n;
		seed = 32'hd8c5d5b5;
		rst = 1'b1;
		req_wr = 1'b0;
		req_func = FN_LOAD;
		req_size = SZ_BYTE;
		req_uns = 1'b0;
		req_tid = '0;
		req_adr = '0;
		req_dat = '0;
		drain_en = 1'b1;
		tid_next = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < 256; i++)
			shadow[8'(i)] = u_mem.mem[8'(i)];

		test_name = "store merge";
		for (int i = 0; i < 24; i++) begin
			sz = 2'(i);
			adr = $random(seed);
			adr[10:3] = 8'd40 + {5'b0, adr[5:3]};	// eight words so stores overlap
			adr[2:0] = adr[2:0] & ~3'((1 << sz) - 1);
			issue(FN_STORE, sz, 1'b0, adr, {$random(seed), $random(seed)});
		end
		for (int w = 0; w < 8; w++)
			issue(FN_LOAD, SZ_OCTA, 1'b0, {21'h0, 8'(40 + w), 3'b000}, '0);
		wait_drained();

		test_name = "extend loads";
		issue(FN_STORE, SZ_OCTA, 1'b0, 32'h0000_0100, 64'h708f_7e6d_c5b4_2a93);
		for (int s = 0; s < 3; s++)
			for (int l = 0; l < 8; l += (1 << s))
				for (int u = 0; u < 2; u++)
					issue(FN_LOAD, 2'(s), 1'(u), 32'h0000_0100 + 32'(l), '0);
		wait_drained();

		test_name = "lea";
		bus_before = bus_count;
		for (int i = 0; i < 6; i++)
			issue(FN_LEA, 2'(i), 1'b0, $random(seed), '0);
		wait_drained();
		if (bus_count != bus_before) begin
			$display("a bus cycle started for an address-only request");
			abort_run();
		end

		test_name = "misaligned and unknown";
		bus_before = bus_count;
		issue(FN_LOAD, SZ_WYDE, 1'b0, 32'h0000_0141, '0);
		issue(FN_STORE, SZ_WYDE, 1'b0, 32'h0000_0143, '1);
		issue(FN_LOAD, SZ_TETRA, 1'b1, 32'h0000_0142, '0);
		issue(FN_STORE, SZ_TETRA, 1'b0, 32'h0000_0146, '1);
		issue(FN_STORE, SZ_OCTA, 1'b0, 32'h0000_0144, '1);
		issue(2'd3, SZ_OCTA, 1'b0, 32'h0000_0140, '0);
		wait_drained();
		if (bus_count != bus_before) begin
			$display("a bus cycle started for a faulting request");
			abort_run();
		end
		issue(FN_LOAD, SZ_OCTA, 1'b0, 32'h0000_0140, '0);	// word must be unchanged
		wait_drained();

		// hold responses until the request FIFO reports full
		test_name = "back-pressure";
		drain_en = 1'b0;
		n = 0;
		full_seen = 1'b0;
		while (!full_seen) begin
			if (n == 64) begin
				$display("request FIFO never filled while responses were held");
				abort_run();
			end else begin
				sz = 2'($random(seed));
				fn = ($random(seed) & 1) ? FN_STORE : FN_LOAD;
				adr = {21'h0, 8'($random(seed)), 3'b000};
				issue(fn, sz, 1'($random(seed)), adr, {$random(seed), $random(seed)});
				@(negedge clk);
				full_seen = req_full;
				n++;
			end
		end
		drain_en = 1'b1;
		wait_drained();

		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== test/wb_mem_model.sv ====
// ======================================
// Wishbone classic slave memory, 256
// words, random wait states, lane writes
// and a count of started bus cycles
// ======================================

`timescale 1ns/1ps

module wb_mem_model import mem_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            wb_cyc_i,
	input  logic            wb_stb_i,
	input  logic            wb_we_i,
	input  logic [SELW-1:0] wb_sel_i,
	input  logic [AWID-1:0] wb_adr_i,
	input  logic [DWID-1:0] wb_dat_i,
	output logic            wb_ack_o,
	output logic [DWID-1:0] wb_dat_o,
	output logic [31:0]     cyc_count_o
);

	logic [DWID-1:0] mem [256];
	logic [7:0] idx;
	logic busy;
	logic [1:0] wait_left;
	logic [1:0] pick;	// next wait length 0 to 3
	integer seed;

	assign idx = wb_adr_i[10:3];	// word address without lane bits

	function automatic logic [DWID-1:0] merge_lanes(input logic [DWID-1:0] old_w,
		input logic [DWID-1:0] new_w, input logic [SELW-1:0] sel);
		logic [DWID-1:0] w;
		w = old_w;
		for (int b = 0; b < SELW; b++)
			if (sel[b])
				w[8*b +: 8] = new_w[8*b +: 8];
		return w;
	endfunction

	// fill pattern spread over the whole word index
	initial begin
		seed = 32'hd8c5d5b5;
		for (int i = 0; i < 256; i++)
			mem[8'(i)] = {32'(i) * 32'h9e3779b9, ~(32'(i) * 32'h85ebca6b)};
	end

	always @(posedge clk) begin
		pick <= 2'($random(seed));
		if (rst) begin
			wb_ack_o <= 1'b0;
			busy <= 1'b0;
			wait_left <= '0;
			cyc_count_o <= '0;
		end else begin
			wb_ack_o <= 1'b0;
			if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
				if (!busy)
					cyc_count_o <= cyc_count_o + 1;	// new cycle seen
				if (!busy && pick != 2'd0) begin
					busy <= 1'b1;
					wait_left <= pick - 1'b1;
				end else if (busy && wait_left != 2'd0) begin
					wait_left <= wait_left - 1'b1;
				end else begin
					busy <= 1'b0;
					wb_ack_o <= 1'b1;
					wb_dat_o <= mem[idx];
					if (wb_we_i)
						mem[idx] <= merge_lanes(mem[idx], wb_dat_i, wb_sel_i);
				end
			end
		end
	end

endmodule
